//--- hdl/field_pkg.sv
package field_pkg;

	//////////////////////////////////////////////////
	// Curve25519 prime field

	// Width of one field element
	localparam int field_w = 256;

	// p = 2^255 - 19
	localparam logic [field_w-1:0] field_p =
		256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;

	// One multiplier bit per iteration
	localparam int mul_steps = 256;

	//////////////////////////////////////////////////
	// Operations and control states

	// Opcodes as written to the command register
	// Anything else is not an operation
	typedef enum logic [7:0] {
		op_add = 8'd1,
		op_sub = 8'd2,
		op_mul = 8'd3
	} field_op_t;

	// Sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_addsub,
		st_mul,
		st_capture
	} seq_state_t;

endpackage

//--- hdl/regmap_pkg.sv
package regmap_pkg;

	// Fixed 16-bit APB, byte addressed
	localparam int apb_data_w = 16;
	localparam int apb_addr_w = 16;

	//////////////////////////////////////////////////
	// Register map

	// Operand and result blocks are 16 words each
	// Word index sits in address bits [4:1]
	typedef enum logic [apb_addr_w-1:0] {
		reg_a      = 16'h000,
		reg_b      = 16'h020,
		reg_status = 16'h040,  // [0] busy
		reg_cmd    = 16'h042,  // [7:0] opcode, write starts it
		reg_result = 16'h060,
		reg_last   = 16'h07f
	} regid_t;

	// Block index from address bits [8:5]
	typedef enum logic [3:0] {
		block_a      = 4'h0,
		block_b      = 4'h1,
		block_ctrl   = 4'h2,
		block_result = 4'h3
	} blockid_t;

endpackage

//--- hdl/field_addsub.sv
`timescale 1ns/1ps

module field_addsub
	import field_pkg::*;
(
	input  logic [field_w-1:0] a,
	input  logic [field_w-1:0] b,
	input  logic               sub_sel,
	output logic [field_w-1:0] sum
);

	// One extra bit for carry and borrow
	logic [field_w:0]   add_raw;
	logic [field_w:0]   add_red;
	logic [field_w:0]   sub_raw;
	logic [field_w:0]   sub_fix;
	logic [field_w-1:0] add_res;
	logic [field_w-1:0] sub_res;

	always_comb begin
		//////////////////////////////////////////////////
		// a + b mod p

		add_raw = {1'b0, a} + {1'b0, b};
		add_red = add_raw - {1'b0, field_p};
		// Fold back once if we reached p
		if (add_raw >= {1'b0, field_p})
			add_res = add_red[field_w-1:0];
		else
			add_res = add_raw[field_w-1:0];

		//////////////////////////////////////////////////
		// a - b mod p

		sub_raw = {1'b0, a} - {1'b0, b};
		sub_fix = sub_raw + {1'b0, field_p};
		// Top bit set means a < b, wrap by adding p
		if (sub_raw[field_w])
			sub_res = sub_fix[field_w-1:0];
		else
			sub_res = sub_raw[field_w-1:0];

		sum = sub_sel ? sub_res : add_res;
	end

endmodule

//--- hdl/field_mul_serial.sv
`timescale 1ns/1ps

module field_mul_serial
	import field_pkg::*;
(
	input  logic               apb,
	input  logic               rst_n,
	input  logic [field_w-1:0] a,
	input  logic [field_w-1:0] b,
	input  logic               mul_start,
	output logic               mul_done,
	output logic [field_w-1:0] product
);

	localparam int cnt_w = $clog2(mul_steps);

	// Multiplier bits left, MSB first
	logic [field_w-1:0] a_sh;
	// Multiplicand held for the whole run
	logic [field_w-1:0] b_hold;
	// Iterations still to go
	logic [cnt_w-1:0]   cnt;
	logic               running;

	//////////////////////////////////////////////////
	// One interleaved step
	// acc = 2*acc mod p, then + b mod p if the bit is set

	function automatic logic [field_w-1:0] mul_step(
		input logic [field_w-1:0] acc,
		input logic               bit_in,
		input logic [field_w-1:0] bv
	);
		logic [field_w:0] dbl;
		logic [field_w:0] add;
		dbl = {acc, 1'b0};
		if (dbl >= {1'b0, field_p})
			dbl = dbl - {1'b0, field_p};
		add = dbl;
		if (bit_in) begin
			add = dbl + {1'b0, bv};
			if (add >= {1'b0, field_p})
				add = add - {1'b0, field_p};
		end
		return add[field_w-1:0];
	endfunction

	//////////////////////////////////////////////////
	// Control

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			running  <= 1'b0;
			mul_done <= 1'b0;
			cnt      <= '0;
		end else begin
			mul_done <= 1'b0;
			if (mul_start) begin
				// First step happens on the start edge
				running <= 1'b1;
				cnt     <= cnt_w'(mul_steps - 1);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				// Last bit goes in this cycle
				if (cnt == 1) begin
					running  <= 1'b0;
					mul_done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Datapath

	always_ff @(posedge apb) begin
		if (mul_start) begin
			// Accumulator starts at zero, so doubling is a no-op
			product <= mul_step('0, a[field_w-1], b);
			a_sh    <= {a[field_w-2:0], 1'b0};
			b_hold  <= b;
		end else if (running) begin
			product <= mul_step(product, a_sh[field_w-1], b_hold);
			a_sh    <= {a_sh[field_w-2:0], 1'b0};
		end
	end

endmodule

//--- hdl/field_sequencer.sv
`timescale 1ns/1ps

module field_sequencer
	import field_pkg::*;
(
	input  logic               apb,
	input  logic               rst_n,

	// Command from the register block
	input  logic               start,
	input  logic [7:0]         op,

	// Datapath results
	input  logic [field_w-1:0] sum,
	input  logic               mul_done,
	input  logic [field_w-1:0] product,

	// Datapath control
	output logic               sub_sel,
	output logic               mul_start,

	// Status and result to the register block
	output logic               busy,
	output logic [field_w-1:0] result
);

	seq_state_t state;

	//////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state     <= st_idle;
			busy      <= 1'b0;
			sub_sel   <= 1'b0;
			mul_start <= 1'b0;
			result    <= '0;
		end else begin
			mul_start <= 1'b0;

			case (state)
				// Commands only accepted here
				st_idle: begin
					if (start) begin
						case (op)
							op_add, op_sub: begin
								// Adder settles during the next cycle
								sub_sel <= (op == op_sub);
								busy    <= 1'b1;
								state   <= st_addsub;
							end
							op_mul: begin
								mul_start <= 1'b1;
								busy      <= 1'b1;
								state     <= st_mul;
							end
							// Unknown opcode, drop it
							default: begin
							end
						endcase
					end
				end

				// Combinational sum is ready, grab it and finish
				st_addsub: begin
					result <= sum;
					busy   <= 1'b0;
					state  <= st_idle;
				end

				// Wait out the serial multiplier
				st_mul: begin
					if (mul_done) begin
						result <= product;
						state  <= st_capture;
					end
				end

				// Release busy one edge after the capture
				st_capture: begin
					busy  <= 1'b0;
					state <= st_idle;
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- hdl/apb_field_regs.sv
`timescale 1ns/1ps

module apb_field_regs
	import field_pkg::*;
	import regmap_pkg::*;
(
	input  logic                  apb,
	input  logic                  rst_n,

	// APB completer
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,

	// From the sequencer
	input  logic                  busy,
	input  logic [field_w-1:0]    result,

	// To the datapath and sequencer
	output logic [field_w-1:0]    a,
	output logic [field_w-1:0]    b,
	output logic                  start,
	output logic [7:0]            op
);

	//////////////////////////////////////////////////
	// Address decode

	// Word within a 256-bit block
	logic [3:0] word_idx;
	// Block selected by the access
	blockid_t   blk;
	// Write inside the map
	logic       wr_ok;

	always_comb begin
		word_idx = paddr[4:1];
		blk      = blockid_t'(paddr[8:5]);
		wr_ok    = pready && pwrite && (paddr <= reg_last);
	end

	//////////////////////////////////////////////////
	// Readback and bus errors

	always_comb begin
		// No wait states
		pready  = psel && penable;
		prdata  = '0;
		pslverr = 1'b0;

		if (pready) begin
			if (pwrite) begin
				// Writes past the end of the map
				if (paddr > reg_last)
					pslverr = 1'b1;
			end else begin
				// Status word
				if (paddr == reg_status)
					prdata = {{(apb_data_w-1){1'b0}}, busy};
				// Result block, one word per access
				else if ((blk == block_result) && (paddr <= reg_last))
					prdata = result[{word_idx, 4'h0} +: apb_data_w];
				// Operands and command are write only
				else
					pslverr = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Command register

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			start <= 1'b0;
			op    <= '0;
		end else begin
			// Single cycle pulse
			start <= 1'b0;

			if (wr_ok && (blk == block_ctrl)) begin
				// Status is read only, write dropped
				if (paddr == reg_cmd) begin
					start <= 1'b1;
					op    <= pwdata[7:0];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Operand registers

	always_ff @(posedge apb) begin
		if (wr_ok) begin
			case (blk)
				// Words land at their index, any order
				block_a: a[{word_idx, 4'h0} +: apb_data_w] <= pwdata;
				block_b: b[{word_idx, 4'h0} +: apb_data_w] <= pwdata;

				// Control handled above, result writes ignored
				default: begin
				end
			endcase
		end
	end

endmodule

//--- hdl/field_accel_top.sv
`timescale 1ns/1ps

module field_accel_top
	import field_pkg::*;
(
	input  logic        apb,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [15:0] paddr,
	input  logic [15:0] pwdata,
	output logic [15:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	//////////////////////////////////////////////////
	// Internal nets

	// Operands from the register block
	logic [field_w-1:0] a;
	logic [field_w-1:0] b;

	// Command path
	logic               start;
	logic [7:0]         op;
	logic               busy;
	logic [field_w-1:0] result;

	// Datapath handshakes
	logic               sub_sel;
	logic [field_w-1:0] sum;
	logic               mul_start;
	logic               mul_done;
	logic [field_w-1:0] product;

	//////////////////////////////////////////////////
	// Bus side

	apb_field_regs u_regs (
		.apb     (apb),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.busy    (busy),
		.result  (result),
		.a       (a),
		.b       (b),
		.start   (start),
		.op      (op)
	);

	//////////////////////////////////////////////////
	// Control and datapath

	field_sequencer u_seq (
		.apb       (apb),
		.rst_n     (rst_n),
		.start     (start),
		.op        (op),
		.sum       (sum),
		.mul_done  (mul_done),
		.product   (product),
		.sub_sel   (sub_sel),
		.mul_start (mul_start),
		.busy      (busy),
		.result    (result)
	);

	// Single cycle add and subtract
	field_addsub u_addsub (
		.a       (a),
		.b       (b),
		.sub_sel (sub_sel),
		.sum     (sum)
	);

	// Multiplier needs mul_steps cycles
	field_mul_serial u_mul (
		.apb       (apb),
		.rst_n     (rst_n),
		.a         (a),
		.b         (b),
		.mul_start (mul_start),
		.mul_done  (mul_done),
		.product   (product)
	);

endmodule

//--- testbench/tb_field_model.svh
`ifndef TB_FIELD_MODEL_SVH
`define TB_FIELD_MODEL_SVH

//////////////////////////////////////////////////
// Reference field model

// 2^255 - 19, built from all ones minus 18
localparam logic [255:0] model_p = {1'b0, {255{1'b1}}} - 256'd18;

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	return s ^ (s << 5);
endfunction

// Wide sum, then a true remainder
function automatic logic [255:0] mod_add(input logic [255:0] x, input logic [255:0] y);
	return 256'(({1'b0, x} + {1'b0, y}) % {1'b0, model_p});
endfunction

// Lift by p first so it never goes negative
function automatic logic [255:0] mod_sub(input logic [255:0] x, input logic [255:0] y);
	return 256'(({1'b0, x} + {1'b0, model_p} - {1'b0, y}) % {1'b0, model_p});
endfunction

// Add-and-double over x, LSB first
function automatic logic [255:0] mod_mul(input logic [255:0] x, input logic [255:0] y);
	logic [255:0] r;
	r = '0;
	for (int i = 0; i < 256; i++) begin
		if (x[i])
			r = mod_add(r, y);
		y = mod_add(y, y);
	end
	return r;
endfunction

// Eight draws, top bit cleared, redrawn until below p
task automatic draw_operand(output logic [255:0] v);
	v = '1;
	while (v >= model_p) begin
		for (int k = 0; k < 8; k++) begin
			rng = xorshift32(rng);
			v[k*32 +: 32] = rng;
		end
		v[255] = 1'b0;
	end
endtask

//////////////////////////////////////////////////
// APB master

// Setup, then access; outputs sampled mid access phase
task automatic apb_transfer(input logic wr, input logic [15:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
	int n;
	@(posedge apb);
	psel   <= 1'b1;
	pwrite <= wr;
	paddr  <= addr;
	pwdata <= wdata;
	@(posedge apb);
	penable <= 1'b1;
	n = 0;
	@(negedge apb);
	while (!pready && n < 8) begin
		@(negedge apb);
		n++;
	end
	if (!pready) begin
		$display("Timeout: no pready for the access at 0x%h", addr);
		errors++;
	end
	rdata = prdata;
	err   = pslverr;
	// Write lands on this edge
	@(posedge apb);
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

// Poll status, 400 cycle budget
task automatic wait_idle();
	logic [15:0] st;
	logic        err;
	int          t0;
	t0 = cycle_cnt;
	st = 16'h1;
	while (st[0] && (cycle_cnt - t0) < 400)
		apb_transfer(1'b0, reg_status, 16'h0, st, err);
	if (st[0]) begin
		$display("Timeout: busy still set after 400 cycles");
		errors++;
	end
endtask

`endif

//--- testbench/tb_field_accel.sv
`timescale 1ns/1ps

module tb_field_accel
	import field_pkg::*;
	import regmap_pkg::*;
();

	logic        apb;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic        pready;
	logic        pslverr;

	// Run bookkeeping
	int          errors    = 0;
	int          tests     = 0;
	int          failed    = 0;
	int          cycle_cnt = 0;
	logic [31:0] rng       = 32'h56caa2b3;

	`include "tb_field_model.svh"

	field_accel_top dut0 (.*);

	// 20 ns period
	initial begin
		apb = 1'b0;
		forever #10 apb = ~apb;
	end

	always @(posedge apb)
		cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////////////////////////
	// Helpers

	task automatic report_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic test_done(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("Test %s: passed", name);
		end else begin
			failed++;
			$display("Test %s: failed with %0d errors", name, errors - mark);
		end
	endtask

	// Reads all 16 result words with pslverr held low
	task automatic read_result(output logic [255:0] v);
		logic [15:0] w;
		logic        err;
		for (int i = 0; i < 16; i++) begin
			apb_transfer(1'b0, 16'(reg_result + 2*i), 16'h0, w, err);
			v[i*16 +: 16] = w;
			if (err !== 1'b0)
				report_value($sformatf("pslverr result word %0d", i), err, 0);
		end
	endtask

	// Operands word by word, then the command
	task automatic issue_op(input logic [7:0] op, input logic [255:0] x,
			input logic [255:0] y);
		logic [15:0] rd;
		logic        err;
		for (int i = 0; i < 16; i++) begin
			apb_transfer(1'b1, 16'(reg_a + 2*i), x[i*16 +: 16], rd, err);
			apb_transfer(1'b1, 16'(reg_b + 2*i), y[i*16 +: 16], rd, err);
		end
		apb_transfer(1'b1, reg_cmd, {8'h00, op}, rd, err);
	endtask

	task automatic run_op(input logic [7:0] op, input logic [255:0] x,
			input logic [255:0] y, output logic [255:0] res);
		issue_op(op, x, y);
		wait_idle();
		read_result(res);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [255:0] x;
		logic [255:0] y;
		logic [255:0] got;
		logic [255:0] first;
		logic [15:0]  w;
		logic         err;
		int           mark;

		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 16'h0;
		pwdata  = 16'h0;
		rst_n   = 1'b0;
		repeat (10) @(posedge apb);
		rst_n <= 1'b1;

		// Idle status, zero result
		mark = errors;
		apb_transfer(1'b0, reg_status, 16'h0, w, err);
		if (w !== 16'h0)
			report_value("prdata status", w, 0);
		if (err !== 1'b0)
			report_value("pslverr status", err, 0);
		read_result(got);
		if (got !== '0)
			report_value("result", got, 0);
		test_done("reset state", mark);

		// Even pairs forced to a < b so the subtract wraps
		mark = errors;
		for (int i = 0; i < 20; i++) begin
			draw_operand(x);
			draw_operand(y);
			if ((i % 2 == 0) && (x > y))
				{x, y} = {y, x};
			run_op(op_add, x, y, got);
			if (got !== mod_add(x, y))
				report_value("result add", got, mod_add(x, y));
			run_op(op_sub, x, y, got);
			if (got !== mod_sub(x, y))
				report_value("result sub", got, mod_sub(x, y));
		end
		test_done("add and subtract", mark);

		// Ten random pairs, then (p-1)*(p-1) and 0*x
		mark = errors;
		for (int i = 0; i < 12; i++) begin
			draw_operand(x);
			draw_operand(y);
			if (i == 10) begin
				x = model_p - 1;
				y = model_p - 1;
			end
			if (i == 11)
				x = '0;
			run_op(op_mul, x, y, got);
			if (got !== mod_mul(x, y))
				report_value("result mul", got, mod_mul(x, y));
		end
		test_done("multiply", mark);

		// Out of map write and reads of write-only registers
		mark = errors;
		apb_transfer(1'b1, 16'h080, 16'h1234, w, err);
		if (err !== 1'b1)
			report_value("pslverr write 0x080", err, 1);
		apb_transfer(1'b0, reg_a, 16'h0, w, err);
		if (err !== 1'b1)
			report_value("pslverr read reg_a", err, 1);
		apb_transfer(1'b0, reg_cmd, 16'h0, w, err);
		if (err !== 1'b1)
			report_value("pslverr read reg_cmd", err, 1);
		apb_transfer(1'b0, reg_status, 16'h0, w, err);
		if (err !== 1'b0)
			report_value("pslverr read reg_status", err, 0);
		read_result(got);
		test_done("bus errors", mark);

		// Opcodes 0 and 7 must not start anything
		// Result still holds the 0*x product with A at zero and B nonzero
		mark = errors;
		first = mod_mul(x, y);
		for (int k = 0; k < 2; k++) begin
			apb_transfer(1'b1, reg_cmd, (k == 0) ? 16'h0000 : 16'h0007, w, err);
			apb_transfer(1'b0, reg_status, 16'h0, w, err);
			if (w[0] !== 1'b0)
				report_value("busy after invalid opcode", w[0], 0);
			read_result(got);
			if (got !== first)
				report_value("result after invalid opcode", got, first);
		end
		// Add issued mid multiply is dropped
		draw_operand(x);
		draw_operand(y);
		issue_op(op_mul, x, y);
		apb_transfer(1'b0, reg_status, 16'h0, w, err);
		if (w[0] !== 1'b1)
			report_value("busy during multiply", w[0], 1);
		apb_transfer(1'b1, reg_cmd, {8'h00, op_add}, w, err);
		wait_idle();
		read_result(got);
		if (got !== mod_mul(x, y))
			report_value("result after busy command", got, mod_mul(x, y));
		test_done("ignored commands", mark);

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+testbench
hdl/field_pkg.sv
hdl/regmap_pkg.sv
hdl/field_addsub.sv
hdl/field_mul_serial.sv
hdl/field_sequencer.sv
hdl/apb_field_regs.sv
hdl/field_accel_top.sv
testbench/tb_field_accel.sv

//--- Bender.yml
package:
  name: field_accel

sources:
  - hdl/field_pkg.sv
  - hdl/regmap_pkg.sv
  - hdl/field_addsub.sv
  - hdl/field_mul_serial.sv
  - hdl/field_sequencer.sv
  - hdl/apb_field_regs.sv
  - hdl/field_accel_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_field_accel.sv
